/* flist.f */
+incdir+common
common/icache_pkg.sv
icache_way/icache_way.sv
source/fetch_ctrl.sv
source/line_select.sv
source/icache_top.sv
bench/tb_clock.sv
bench/tb_icache.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = tb_icache
FLIST     = flist.f
OBJ_DIR   = obj_dir
PASS_MSG  = *** PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

# the result is decided by the pass line in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

/* bench/tb_icache.sv */
`include "icache_consts.svh"

module tb_icache import icache_pkg::*;;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int SETS        = 1 << `ICACHE_INDEX_BITS;
	localparam int N_RAND      = 400;
	// upper bound on directed and drain cycles
	localparam int N_DIRECTED  = 40;
	localparam int N_REQ       = N_RAND + N_DIRECTED;
	localparam int WATCHDOG_NS = N_REQ * 200 + 8 * 100;
	localparam logic [`ICACHE_TAG_BITS-1:0] TAG_BASE = 54'h2_a5c3_0071_1e00;

	logic        clk;
	logic        rst;
	logic        valid;
	logic        flush;
	fetch_addr_u addr;
	line_t       mem_line;
	logic        ready;
	logic [31:0] inst;
	logic        mem_req;
	logic [`ICACHE_ADDR_BITS-1:0] mem_addr;

	// expectations for the cycle in flight
	logic        cur_go;
	logic [31:0] cur_word;
	logic        exp_miss;
	logic [`ICACHE_ADDR_BITS-1:0] exp_line_addr;
	// expectations for the result cycle
	logic        exp_ready;
	logic [31:0] exp_inst;

	// reference copy of the cache contents
	logic [`ICACHE_TAG_BITS-1:0] model_tag [SETS][`ICACHE_WAYS];
	logic                        model_vld [SETS][`ICACHE_WAYS];
	int                          model_victim;

	integer seed;
	int     err_count = 0;

	tb_clock clock_i (
		.clk (clk),
		.rst (rst)
	);

	icache_top dut_i (
		.clk      (clk),
		.rst      (rst),
		.valid    (valid),
		.flush    (flush),
		.addr     (addr),
		.mem_line (mem_line),
		.ready    (ready),
		.inst     (inst),
		.mem_req  (mem_req),
		.mem_addr (mem_addr)
	);

	// memory word at byte address a, a fixed scramble of the whole address
	function automatic logic [31:0] word_at(input logic [63:0] a);
		logic [31:0] lo;
		logic [31:0] hi;
		lo = a[31:0];
		hi = a[63:32];
		return (lo * 32'h9e37_79b1) ^ {hi[15:0], hi[31:16]} ^ 32'h5a17_c3e9;
	endfunction

	// backing memory answers in the same cycle, word 0 in the low bits
	always_comb begin
		for (int i = 0; i < 4; i++) begin
			mem_line[32*i +: 32] = word_at(mem_addr + 64'(4 * i));
		end
	end

	function automatic logic [63:0] make_addr(input int tag_sel, input int idx,
		input logic [1:0] word);
		fetch_addr_u a;
		a.raw            = '0;
		a.fields.tag      = TAG_BASE + 54'(tag_sel) * 54'h1_0001;
		a.fields.index    = 6'(idx);
		a.fields.word_sel = word;
		return a.raw;
	endfunction

	function automatic logic resident(input logic [63:0] a);
		fetch_addr_u f;
		logic        found;
		f.raw = a;
		found = 1'b0;
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			if (model_vld[f.fields.index][w] && model_tag[f.fields.index][w] == f.fields.tag) begin
				found = 1'b1;
			end
		end
		return found;
	endfunction

	// refill goes to the victim, which then moves one way on
	task automatic fill_model(input logic [63:0] a);
		fetch_addr_u f;
		f.raw = a;
		model_tag[f.fields.index][model_victim] = f.fields.tag;
		model_vld[f.fields.index][model_victim] = 1'b1;
		model_victim = (model_victim + 1) % `ICACHE_WAYS;
	endtask

	// one fetch cycle, inputs change on the rising edge
	task automatic issue(input logic v, input logic f, input logic [63:0] a);
		logic go;
		logic res;
		@(posedge clk);
		go  = v && !f;
		res = resident(a);
		valid         <= v;
		flush         <= f;
		addr.raw      <= a;
		cur_go        <= go;
		cur_word      <= word_at({a[63:2], 2'b00});
		exp_miss      <= go && !res;
		exp_line_addr <= {a[63:4], 4'h0};
		if (go && !res) begin
			fill_model(a);
		end
	endtask

	task automatic stop_fail(input string why);
		err_count++;
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1, "stopped at first error");
	endtask

	// fixed latency of one, so the result follows the request by one edge
	always_ff @(posedge clk) begin
		if (rst) begin
			exp_ready <= 1'b0;
			exp_inst  <= '0;
		end else begin
			exp_ready <= cur_go;
			exp_inst  <= cur_word;
		end
	end

	chk_ready: assert property (@(posedge clk) disable iff (rst) ready == exp_ready)
		else begin
			$display("MISMATCH at %0t: ready %b, expected %b", $time,
				$sampled(ready), $sampled(exp_ready));
			stop_fail("ready check failed");
		end

	chk_inst: assert property (@(posedge clk) disable iff (rst) exp_ready |-> inst == exp_inst)
		else begin
			$display("MISMATCH at %0t: inst %h, expected %h", $time,
				$sampled(inst), $sampled(exp_inst));
			stop_fail("instruction check failed");
		end

	// hit or miss against the reference contents
	chk_miss: assert property (@(posedge clk) disable iff (rst) mem_req == exp_miss)
		else begin
			$display("MISMATCH at %0t: mem_req %b, expected %b", $time,
				$sampled(mem_req), $sampled(exp_miss));
			stop_fail("memory request check failed");
		end

	chk_line_addr: assert property (@(posedge clk) disable iff (rst)
		mem_req |-> mem_addr == exp_line_addr)
		else begin
			$display("MISMATCH at %0t: mem_addr %h, expected %h", $time,
				$sampled(mem_addr), $sampled(exp_line_addr));
			stop_fail("memory address check failed");
		end

	initial begin
		#(WATCHDOG_NS);
		stop_fail("timeout: the run did not finish in time");
	end

	initial begin
		logic [31:0] r;
		int          t;
		int          k;
		int          idx;
		seed         = 83;
		model_victim = 0;
		for (int s = 0; s < SETS; s++) begin
			for (int w = 0; w < `ICACHE_WAYS; w++) begin
				model_vld[s][w] = 1'b0;
				model_tag[s][w] = '0;
			end
		end
		valid         <= 1'b0;
		flush         <= 1'b0;
		addr          <= '0;
		cur_go        <= 1'b0;
		cur_word      <= '0;
		exp_miss      <= 1'b0;
		exp_line_addr <= '0;
		@(posedge clk);
		while (rst) @(posedge clk);

		// cold miss, then the same line hits
		issue(1'b1, 1'b0, make_addr(0, 5, 2'd1));
		issue(1'b1, 1'b0, make_addr(0, 5, 2'd1));
		issue(1'b1, 1'b0, make_addr(0, 5, 2'd3));
		issue(1'b0, 1'b0, '0);
		issue(1'b0, 1'b0, '0);

		// five tags into set 9, first one gets evicted
		for (t = 0; t < 5; t++) begin
			issue(1'b1, 1'b0, make_addr(t, 9, 2'(t)));
		end
		for (t = 1; t < 5; t++) begin
			issue(1'b1, 1'b0, make_addr(t, 9, 2'd0));
		end
		issue(1'b1, 1'b0, make_addr(0, 9, 2'd2));

		// flushed requests must not fill
		issue(1'b1, 1'b1, make_addr(3, 21, 2'd0));
		issue(1'b1, 1'b0, make_addr(3, 21, 2'd0));
		issue(1'b1, 1'b1, make_addr(3, 21, 2'd1));
		issue(1'b0, 1'b0, '0);

		// random mix over a few tags and sets
		for (int n = 0; n < N_RAND; n++) begin
			r   = $random(seed);
			t   = r[15:8] % 6;
			k   = r[23:16] % 3;
			idx = (k == 0) ? 3 : (k == 1) ? 17 : 40;
			issue(r[1:0] != 2'b00, r[4:2] == 3'b000, make_addr(t, idx, r[25:24]));
		end

		// drain the last result
		issue(1'b0, 1'b0, '0);
		issue(1'b0, 1'b0, '0);
		@(posedge clk);
		// the checks of the last rising edge complete before the verdict
		@(negedge clk);
		if (err_count == 0) begin
			$display("*** PASSED ***");
			$finish;
		end else begin
			stop_fail("errors were counted during the run");
		end
	end

endmodule

/* bench/tb_clock.sv */
module tb_clock (
	output logic clk,
	output logic rst
);

	timeunit 1ns;
	timeprecision 100ps;

	// 100 ns period
	localparam int HALF_NS      = 50;
	localparam int RESET_CYCLES = 8;

	initial begin
		clk = 1'b0;
		forever #HALF_NS clk = ~clk;
	end

	// synchronous reset, dropped on a rising edge after 8 cycles
	initial begin
		rst <= 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

/* source/icache_top.sv */
`include "icache_consts.svh"

module icache_top import icache_pkg::*; (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         valid,
	input  logic                         flush,
	input  fetch_addr_u                  addr,
	input  line_t                        mem_line,
	output logic                         ready,
	output logic [31:0]                  inst,
	output logic                         mem_req,
	output logic [`ICACHE_ADDR_BITS-1:0] mem_addr
);

	// controller to ways
	way_ctl_t [`ICACHE_WAYS-1:0] way_ctl;
	// ways back to controller and selector
	logic [`ICACHE_WAYS-1:0]     way_hit;
	line_t [`ICACHE_WAYS-1:0]    way_rdata;

	// controller to selector
	logic [`ICACHE_WAYS-1:0]     req_hit;
	logic                        req_go;
	logic [1:0]                  word_sel;

	fetch_ctrl ctrl_i (
		.clk      (clk),
		.rst      (rst),
		.valid    (valid),
		.flush    (flush),
		.addr     (addr),
		.hit      (way_hit),
		.way_ctl  (way_ctl),
		.mem_req  (mem_req),
		.mem_addr (mem_addr),
		.req_hit  (req_hit),
		.req_go   (req_go),
		.word_sel (word_sel)
	);

	// all ways share the refill bus, fill_en decides who writes
	for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
		icache_way way_i (
			.clk       (clk),
			.rst       (rst),
			.ctl       (way_ctl[w]),
			.fill_line (mem_line),
			.hit       (way_hit[w]),
			.rdata     (way_rdata[w])
		);
	end

	line_select sel_i (
		.clk       (clk),
		.rst       (rst),
		.req_go    (req_go),
		.req_hit   (req_hit),
		.word_sel  (word_sel),
		.mem_line  (mem_line),
		.way_rdata (way_rdata),
		.ready     (ready),
		.inst      (inst)
	);

endmodule

/* source/line_select.sv */
`include "icache_consts.svh"

module line_select import icache_pkg::*; (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    req_go,
	input  logic [`ICACHE_WAYS-1:0] req_hit,
	input  logic [1:0]              word_sel,
	input  line_t                   mem_line,
	input  line_t [`ICACHE_WAYS-1:0] way_rdata,
	output logic                    ready,
	output logic [31:0]             inst
);

	// state of the request that was looked up last cycle
	logic [`ICACHE_WAYS-1:0] hit_q;
	logic [1:0]              word_q;
	// refill line kept for the miss case, the way only has it after the edge
	line_t                   refill_q;

	// line picked for output
	line_t                   line_sel;

	// no request or a flushed one leaves nothing pending
	always_ff @(posedge clk) begin
		if (rst || !req_go) begin
			ready    <= 1'b0;
			hit_q    <= '0;
			word_q   <= '0;
			refill_q <= '0;
		end else begin
			ready    <= 1'b1;
			hit_q    <= req_hit;
			word_q   <= word_sel;
			refill_q <= mem_line;
		end
	end

	// hit_q is one-hot or zero
	// zero means last request missed, so take the refill line
	always_comb begin
		line_sel = refill_q;
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			if (hit_q[w]) begin
				line_sel = way_rdata[w];
			end
		end
	end

	// word 0 sits in the low 32 bits
	assign inst = line_sel[{word_q, 5'd0} +: 32];

endmodule

/* source/fetch_ctrl.sv */
`include "icache_consts.svh"

module fetch_ctrl import icache_pkg::*; (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         valid,
	input  logic                         flush,
	input  fetch_addr_u                  addr,
	input  logic [`ICACHE_WAYS-1:0]      hit,
	output way_ctl_t [`ICACHE_WAYS-1:0]  way_ctl,
	output logic                         mem_req,
	output logic [`ICACHE_ADDR_BITS-1:0] mem_addr,
	output logic [`ICACHE_WAYS-1:0]      req_hit,
	output logic                         req_go,
	output logic [1:0]                   word_sel
);

	logic                    any_hit;
	logic                    fill;
	// one-hot, picks the way that takes the next refill
	logic [`ICACHE_WAYS-1:0] victim;

	// a request only counts when it is not flushed in the same cycle
	assign req_go = valid && !flush;

	// at most one way can match, so a plain or is enough
	assign any_hit = |hit;

	// miss -> fetch the whole line and drop it into the victim way
	assign fill    = req_go && !any_hit;
	assign mem_req = fill;

	// line aligned, the memory always returns the full 128 bits
	assign mem_addr = {addr.raw[`ICACHE_ADDR_BITS-1:`ICACHE_OFFSET_BITS],
		{`ICACHE_OFFSET_BITS{1'b0}}};

	// hit vector handed on only for live requests
	assign req_hit  = req_go ? hit : '0;
	assign word_sel = addr.fields.word_sel;

	// every way sees the same index and tag for its compare
	always_comb begin
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			way_ctl[w].index   = addr.fields.index;
			way_ctl[w].tag     = addr.fields.tag;
			// read only in the way that actually holds the line
			way_ctl[w].rd_en   = req_go && hit[w];
			// write only in the chosen victim, and only on a miss
			way_ctl[w].fill_en = fill && victim[w];
		end
	end

	// victim rotates one place per fill and stays put otherwise,
	// so the eviction order is easy to predict
	always_ff @(posedge clk) begin
		if (rst) begin
			victim <= {{(`ICACHE_WAYS-1){1'b0}}, 1'b1};
		end else if (fill) begin
			victim <= {victim[`ICACHE_WAYS-2:0], victim[`ICACHE_WAYS-1]};
		end
	end

endmodule

/* icache_way/icache_way.sv */
`include "icache_consts.svh"

module icache_way import icache_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  way_ctl_t ctl,
	input  line_t    fill_line,
	output logic     hit,
	output line_t    rdata
);

	localparam int SETS = 1 << `ICACHE_INDEX_BITS;

	// one valid bit and one tag per set
	logic [SETS-1:0]             valid_bits;
	logic [`ICACHE_TAG_BITS-1:0] tags [SETS];

	// line storage, behaves like a single-port ram
	line_t lines [SETS];

	// stored tag of the addressed set
	logic [`ICACHE_TAG_BITS-1:0] cur_tag;
	logic                        cur_valid;

	assign cur_tag   = tags[ctl.index];
	assign cur_valid = valid_bits[ctl.index];

	// purely combinational, the controller needs it in the same cycle
	assign hit = cur_valid && (cur_tag == ctl.tag);

	// tag and valid state
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_bits <= '0;
			for (int s = 0; s < SETS; s++) begin
				tags[s] <= '0;
			end
		end else if (ctl.fill_en) begin
			// new line becomes visible to the very next lookup
			valid_bits[ctl.index] <= 1'b1;
			tags[ctl.index]       <= ctl.tag;
		end
	end

	// line write on refill
	always_ff @(posedge clk) begin
		if (ctl.fill_en) begin
			lines[ctl.index] <= fill_line;
		end
	end

	// registered read, data shows up one cycle after the hit
	// rdata holds its old value when the way is not read
	always_ff @(posedge clk) begin
		if (ctl.rd_en) begin
			rdata <= lines[ctl.index];
		end
	end

endmodule

/* common/icache_pkg.sv */
`include "icache_consts.svh"

package icache_pkg;

	// fetch address split into cache fields
	// msb first: tag, set index, word in line, byte in word
	typedef struct packed {
		logic [`ICACHE_TAG_BITS-1:0]   tag;
		logic [`ICACHE_INDEX_BITS-1:0] index;
		logic [1:0]                    word_sel;
		logic [1:0]                    byte_sel;
	} fetch_fields_t;

	// same fetch address, seen either as a plain memory address
	// or as the decoded cache fields
	typedef union packed {
		logic [`ICACHE_ADDR_BITS-1:0] raw;
		fetch_fields_t                fields;
	} fetch_addr_u;

	// per-way control from the fetch controller
	// rd_en only goes to the hitting way, fill_en only to the victim
	typedef struct packed {
		logic [`ICACHE_INDEX_BITS-1:0] index;
		logic [`ICACHE_TAG_BITS-1:0]   tag;
		logic                          rd_en;
		logic                          fill_en;
	} way_ctl_t;

	// one cache line, word 0 in the low bits
	typedef logic [`ICACHE_LINE_BITS-1:0] line_t;

endpackage

/* common/icache_consts.svh */
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// fetch address width, full 64-bit pc
`define ICACHE_ADDR_BITS 64

// byte offset inside one 128-bit line
`define ICACHE_OFFSET_BITS 4

// 64 sets
`define ICACHE_INDEX_BITS 6

// whatever is left above index and offset
`define ICACHE_TAG_BITS 54

// associativity
`define ICACHE_WAYS 4

// one line holds four 32-bit instructions
`define ICACHE_LINE_BITS 128

`endif
